//--- Bender.yml
package:
  name: wb_stream

sources:
  - stream_pkg.sv
  - stream_fifo.sv
  - wb_stream_bridge.sv
  - stream_accum_stage.sv
  - stream_clip_stage.sv
  - wb_stream_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_wb_stream.sv

//--- sim.f
stream_pkg.sv
stream_fifo.sv
wb_stream_bridge.sv
stream_accum_stage.sv
stream_clip_stage.sv
wb_stream_top.sv
tb_clk_gen.sv
tb_wb_stream.sv

//--- stream_accum_stage.sv
/* one-entry pipeline stage keeping a running sum of its input
   the sum wraps modulo 2**DATA_W and only reset clears it */
`timescale 1ns/1ns

module stream_accum_stage import stream_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,

  // samples in
  input  logic              in_val_i,
  input  logic [DATA_W-1:0] in_data_i,
  output logic              in_rdy_o,

  // running sums out
  output logic              out_val_o,
  output logic [DATA_W-1:0] out_data_o,
  input  logic              out_rdy_i
);

  logic [DATA_W-1:0] sum_r;
  logic [DATA_W-1:0] sum_next;
  logic              out_val_r;
  logic              take_in;

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  // free when empty or when the held item leaves this cycle
  assign in_rdy_o = !out_val_r || out_rdy_i;
  assign take_in  = in_val_i && in_rdy_o;

  ////////////////////////////////////////////////////////////
  // accumulator
  ////////////////////////////////////////////////////////////

  assign sum_next = sum_r + in_data_i;

  // the sum register doubles as the output item
  // it only moves when a new sample is taken
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sum_r     <= '0;
      out_val_r <= 1'b0;
    end else begin
      if (take_in) begin
        sum_r     <= sum_next;
        out_val_r <= 1'b1;
      end else if (out_rdy_i) begin
        out_val_r <= 1'b0;
      end
    end
  end

  assign out_val_o  = out_val_r;
  assign out_data_o = sum_r;

  // a stalled item keeps its value until taken
  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (out_val_o && !out_rdy_i) |=> $stable(out_data_o));

endmodule

//--- stream_clip_stage.sv
/* one-entry pipeline stage clamping a signed input to +/- p_clip_limit
   p_clip_limit must be positive and fit in DATA_W-1 bits */
`timescale 1ns/1ns

module stream_clip_stage import stream_pkg::*; #(
  parameter int p_clip_limit = 1000
) (
  input  logic              clk,
  input  logic              rst_n_i,

  input  logic              in_val_i,
  input  logic [DATA_W-1:0] in_data_i,
  output logic              in_rdy_o,

  output logic              out_val_o,
  output logic [DATA_W-1:0] out_data_o,
  input  logic              out_rdy_i
);

  localparam logic signed [DATA_W-1:0] c_hi = DATA_W'(p_clip_limit);
  localparam logic signed [DATA_W-1:0] c_lo = -c_hi;

  logic signed [DATA_W-1:0] in_s;
  logic signed [DATA_W-1:0] clipped;
  logic [DATA_W-1:0]        out_data_r;
  logic                     out_val_r;
  logic                     take_in;

  assign in_rdy_o = !out_val_r || out_rdy_i;
  assign take_in  = in_val_i && in_rdy_o;

  // saturation
  assign in_s    = $signed(in_data_i);
  assign clipped = (in_s > c_hi) ? c_hi :
                   (in_s < c_lo) ? c_lo : in_s;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out_val_r <= 1'b0;
    end else if (take_in) begin
      out_val_r <= 1'b1;
    end else if (out_rdy_i) begin
      out_val_r <= 1'b0;
    end
  end

  // held item
  always_ff @(posedge clk) begin
    if (take_in) begin
      out_data_r <= clipped;
    end
  end

  assign out_val_o  = out_val_r;
  assign out_data_o = out_data_r;

  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (out_val_o && !out_rdy_i) |=> $stable(out_data_o));

endmodule

//--- stream_fifo.sv
/* valid/ready queue of DATA_W messages, p_depth must be at least 1
   enqueue and dequeue can fire in the same cycle, also when full
   deq_data_o only carries a message while deq_val_o is high */
`timescale 1ns/1ns

module stream_fifo import stream_pkg::*; #(
  parameter int p_depth = 2
) (
  input  logic              clk,
  input  logic              rst_n_i,

  input  logic              enq_val_i,
  input  logic [DATA_W-1:0] enq_data_i,
  output logic              enq_rdy_o,

  output logic              deq_val_o,
  output logic [DATA_W-1:0] deq_data_o,
  input  logic              deq_rdy_i
);

  localparam int c_ptr_w = (p_depth > 1) ? $clog2(p_depth) : 1;
  localparam int c_cnt_w = $clog2(p_depth + 1);
  localparam logic [c_ptr_w-1:0] c_last = c_ptr_w'(p_depth - 1);
  localparam logic [c_cnt_w-1:0] c_full = c_cnt_w'(p_depth);

  logic [DATA_W-1:0]  mem_r [p_depth];
  logic [c_ptr_w-1:0] wr_ptr_r;
  logic [c_ptr_w-1:0] rd_ptr_r;
  logic [c_cnt_w-1:0] cnt_r;
  logic               do_enq;
  logic               do_deq;

  // a full queue still takes a message when the head leaves this cycle
  assign enq_rdy_o  = (cnt_r != c_full) || deq_rdy_i;
  assign deq_val_o  = (cnt_r != '0);
  assign deq_data_o = mem_r[rd_ptr_r];

  assign do_enq = enq_val_i && enq_rdy_o;
  assign do_deq = deq_val_o && deq_rdy_i;

  // storage
  always_ff @(posedge clk) begin
    if (do_enq) begin
      mem_r[wr_ptr_r] <= enq_data_i;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      cnt_r    <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr_r <= (wr_ptr_r == c_last) ? '0 : wr_ptr_r + 1'b1;
      end
      if (do_deq) begin
        rd_ptr_r <= (rd_ptr_r == c_last) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({do_enq, do_deq})
        2'b10:   cnt_r <= cnt_r + 1'b1;
        2'b01:   cnt_r <= cnt_r - 1'b1;
        default: cnt_r <= cnt_r;
      endcase
    end
  end

  // occupancy stays within the storage
  a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
    cnt_r <= c_full);

endmodule

//--- stream_pkg.sv
/* shared constants of the wishbone stream accelerator
   channel slots are 8 bytes wide, with the input slots starting at ISTREAM_BASE
   the output slots follow the last input slot */
package stream_pkg;

  ////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////

  // width of bus words and of stream messages
  localparam int DATA_W = 32;

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////

  // status word of input channel 0
  localparam logic [DATA_W-1:0] ISTREAM_BASE = 32'h3000_0000;

  // byte stride between channel slots
  localparam int SLOT_BYTES = 8;

  // address bits below the channel index
  localparam int SLOT_SHIFT = $clog2(SLOT_BYTES);

  ////////////////////////////////////////////////////////////
  // register offsets inside a slot
  ////////////////////////////////////////////////////////////

  // status word
  // input side reads queue-can-accept, output side reads queue-holds-data
  localparam logic [SLOT_SHIFT-1:0] OFS_STATUS = SLOT_SHIFT'(0);

  // data word
  // write pushes a sample in, read pops a result out
  localparam logic [SLOT_SHIFT-1:0] OFS_DATA = SLOT_SHIFT'(4);

endpackage

//--- tb_clk_gen.sv
/* free-running testbench clock, starts low
   p_period should be even */
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int p_period = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(p_period / 2) clk_o = ~clk_o;
    end
  end

endmodule

//--- tb_wb_stream.sv
/* testbench for wb_stream_top with two channels, queue depth 2 and limit 1000
   expected results come from a wrapping sum and clamp model per channel */
`timescale 1ns/1ns

module tb_wb_stream import stream_pkg::*;;

  localparam int c_num_chan = 2;
  localparam int c_num_msgs = 2;
  localparam int c_clip     = 1000;
  localparam int c_period   = 40;
  localparam int c_tab_len  = 9;
  localparam int c_poll_max = 50;
  localparam int c_cap      = 2 * c_num_msgs + 2;

  logic              clk;
  logic              rst_n;
  logic              wbs_cyc;
  logic              wbs_stb;
  logic              wbs_we;
  logic [DATA_W-1:0] wbs_adr;
  logic [DATA_W-1:0] wbs_dat_w;
  logic              wbs_ack;
  logic [DATA_W-1:0] wbs_dat_r;
  int                errors = 0;
  logic [DATA_W-1:0] seed   = 32'h59ee;

  // model state
  logic [DATA_W-1:0] model_sum [c_num_chan];
  logic [DATA_W-1:0] exp_q [c_num_chan][$];

  // stimulus table with the channels interleaved
  // rows 5 to 7 saturate, rows 8 and 9 come back inside the limit
  int tab_chan [c_tab_len] = '{0, 1, 0, 1, 0, 0, 1, 1, 0};
  int tab_smp  [c_tab_len] = '{5, -3, 10, 7, 2000, -100, -3000, 2500, -1900};
  int tab_exp  [c_tab_len] = '{5, -3, 15, 4, 1000, 1000, -1000, -496, 15};

  tb_clk_gen #(.p_period(c_period)) u_clk (.clk_o(clk));

  wb_stream_top #(
    .p_num_chan   (c_num_chan),
    .p_num_msgs   (c_num_msgs),
    .p_clip_limit (c_clip)
  ) u_dut (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .wbs_cyc_i (wbs_cyc),
    .wbs_stb_i (wbs_stb),
    .wbs_we_i  (wbs_we),
    .wbs_adr_i (wbs_adr),
    .wbs_dat_i (wbs_dat_w),
    .wbs_ack_o (wbs_ack),
    .wbs_dat_o (wbs_dat_r)
  );

  ////////////////////////////////////////////////////////////
  // model and helpers
  ////////////////////////////////////////////////////////////

  // side 0 is the input slots, side 1 the output slots
  function automatic logic [DATA_W-1:0] slot_addr(input int side, input int ch, input int ofs);
    return ISTREAM_BASE + DATA_W'((side * c_num_chan + ch) * SLOT_BYTES + ofs);
  endfunction

  function automatic logic [DATA_W-1:0] clamp(input logic [DATA_W-1:0] v);
    int s;
    s = $signed(v);
    if (s > c_clip) begin
      return DATA_W'(c_clip);
    end else if (s < -c_clip) begin
      return DATA_W'(-c_clip);
    end
    return v;
  endfunction

  function automatic logic [DATA_W-1:0] lcg_next(input logic [DATA_W-1:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // small signed filler, -128 to 127
  task automatic filler(output logic [DATA_W-1:0] smp);
    seed = lcg_next(seed);
    smp  = DATA_W'(int'(seed[23:16]) - 128);
  endtask

  task automatic model_push(input int ch, input logic [DATA_W-1:0] smp);
    model_sum[ch] = model_sum[ch] + smp;
    exp_q[ch].push_back(clamp(model_sum[ch]));
  endtask

  task automatic check_val(input string name, input logic [DATA_W-1:0] exp,
                           input logic [DATA_W-1:0] act);
    if (exp !== act) begin
      errors++;
      $display("mismatch %s: expected %h, got %h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus transfers, one cycle each, followed by an idle cycle
  ////////////////////////////////////////////////////////////

  task automatic wb_write(input logic [DATA_W-1:0] adr, input logic [DATA_W-1:0] dat);
    @(negedge clk);
    wbs_cyc   = 1'b1;
    wbs_stb   = 1'b1;
    wbs_we    = 1'b1;
    wbs_adr   = adr;
    wbs_dat_w = dat;
    #(c_period / 4);
    check_val("wbs_ack_o", 1, DATA_W'(wbs_ack));
    @(negedge clk);
    wbs_cyc = 1'b0;
    wbs_stb = 1'b0;
    wbs_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [DATA_W-1:0] adr, output logic [DATA_W-1:0] dat);
    @(negedge clk);
    wbs_cyc = 1'b1;
    wbs_stb = 1'b1;
    wbs_we  = 1'b0;
    wbs_adr = adr;
    // read data settles well before the rising edge
    #(c_period / 4);
    dat = wbs_dat_r;
    check_val("wbs_ack_o", 1, DATA_W'(wbs_ack));
    @(negedge clk);
    wbs_cyc = 1'b0;
    wbs_stb = 1'b0;
  endtask

  // pop every expected result of a channel, polling its status first
  task automatic drain_chan(input int ch);
    logic [DATA_W-1:0] rd;
    int                polls;
    while (exp_q[ch].size() > 0) begin
      polls = 0;
      rd    = '0;
      while (rd != 1 && polls < c_poll_max) begin
        wb_read(slot_addr(1, ch, OFS_STATUS), rd);
        polls++;
      end
      if (rd != 1) begin
        errors++;
        $display("channel %0d gave no result within %0d status polls", ch, c_poll_max);
        return;
      end
      wb_read(slot_addr(1, ch, OFS_DATA), rd);
      check_val($sformatf("wbs_dat_o ch%0d", ch), exp_q[ch].pop_front(), rd);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] smp;
    wbs_cyc   = 1'b0;
    wbs_stb   = 1'b0;
    wbs_we    = 1'b0;
    wbs_adr   = '0;
    wbs_dat_w = '0;
    rst_n     = 1'b0;
    for (int k = 0; k < c_num_chan; k++) begin
      model_sum[k] = '0;
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // idle state after reset
    for (int k = 0; k < c_num_chan; k++) begin
      wb_read(slot_addr(0, k, OFS_STATUS), rd);
      check_val("wbs_dat_o in_status", 1, rd);
      wb_read(slot_addr(1, k, OFS_STATUS), rd);
      check_val("wbs_dat_o out_status", 0, rd);
      wb_read(slot_addr(1, k, OFS_DATA), rd);
      check_val("wbs_dat_o out_data", 0, rd);
    end

    // table rows, then drain per channel in write order
    for (int i = 0; i < c_tab_len; i++) begin
      wb_write(slot_addr(0, tab_chan[i], OFS_DATA), DATA_W'(tab_smp[i]));
      model_push(tab_chan[i], DATA_W'(tab_smp[i]));
      check_val($sformatf("tab_exp[%0d]", i), clamp(model_sum[tab_chan[i]]),
                DATA_W'(tab_exp[i]));
    end
    for (int k = 0; k < c_num_chan; k++) begin
      drain_chan(k);
    end

    // back-pressure on channel 1, the last two writes are dropped
    for (int i = 0; i < c_cap + 2; i++) begin
      filler(smp);
      wb_write(slot_addr(0, 1, OFS_DATA), smp);
      if (i < c_cap) begin
        model_push(1, smp);
      end
    end
    repeat (20) @(negedge clk);
    wb_read(slot_addr(0, 1, OFS_STATUS), rd);
    check_val("wbs_dat_o in_status", 0, rd);
    drain_chan(1);
    wb_read(slot_addr(1, 1, OFS_STATUS), rd);
    check_val("wbs_dat_o out_status", 0, rd);

    // unmapped reads and stray writes
    wb_read(ISTREAM_BASE - 4, rd);
    check_val("wbs_dat_o unmapped", 0, rd);
    wb_read(slot_addr(2, 0, OFS_STATUS), rd);
    check_val("wbs_dat_o unmapped", 0, rd);
    wb_read(ISTREAM_BASE + 2, rd);
    check_val("wbs_dat_o unmapped", 0, rd);
    filler(smp);
    wb_write(ISTREAM_BASE + 2, smp);
    wb_write(slot_addr(0, 0, OFS_STATUS), smp);
    wb_write(slot_addr(1, 0, OFS_STATUS), smp);
    wb_write(slot_addr(2, 0, OFS_DATA), smp);
    for (int i = 0; i < 3; i++) begin
      filler(smp);
      wb_write(slot_addr(0, 0, OFS_DATA), smp);
      model_push(0, smp);
    end
    drain_chan(0);

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(c_tab_len * 200 * c_period);
    $display("run did not finish within %0d cycles", c_tab_len * 200);
    $display("test failed");
    $finish;
  end

endmodule

//--- wb_stream_bridge.sv
/* wishbone slave with the stream address map, ack is always high
   no error, retry, byte select or burst support
   a write to a full input queue is dropped without notice */
`timescale 1ns/1ns

module wb_stream_bridge import stream_pkg::*; #(
  parameter int p_num_chan = 2,
  parameter int p_num_msgs = 2
) (
  input  logic                  clk,
  input  logic                  rst_n_i,

  // wishbone slave
  input  logic                  wbs_cyc_i,
  input  logic                  wbs_stb_i,
  input  logic                  wbs_we_i,
  input  logic [DATA_W-1:0]     wbs_adr_i,
  input  logic [DATA_W-1:0]     wbs_dat_i,
  output logic                  wbs_ack_o,
  output logic [DATA_W-1:0]     wbs_dat_o,

  // toward the pipelines
  output logic [p_num_chan-1:0] in_val_o,
  output logic [DATA_W-1:0]     in_data_o [p_num_chan],
  input  logic [p_num_chan-1:0] in_rdy_i,

  // back from the pipelines
  input  logic [p_num_chan-1:0] out_val_i,
  input  logic [DATA_W-1:0]     out_data_i [p_num_chan],
  output logic [p_num_chan-1:0] out_rdy_o
);

  localparam int c_chan_w = (p_num_chan > 1) ? $clog2(p_num_chan) : 1;
  localparam logic [DATA_W-1:0] c_span = DATA_W'(p_num_chan * SLOT_BYTES);
  localparam logic [DATA_W-1:0] c_ostream_base = ISTREAM_BASE + c_span;

  ////////////////////////////////////////////////////////////
  // address decoder
  ////////////////////////////////////////////////////////////

  logic                xfer;
  logic [DATA_W-1:0]   in_rel;
  logic [DATA_W-1:0]   out_rel;
  logic                in_hit;
  logic                out_hit;
  logic [c_chan_w-1:0] in_idx;
  logic [c_chan_w-1:0] out_idx;
  logic                rd_in_status;
  logic                wr_in_data;
  logic                rd_out_status;
  logic                rd_out_data;

  assign xfer = wbs_cyc_i && wbs_stb_i;

  // addresses below a base wrap to large offsets and miss the span
  assign in_rel  = wbs_adr_i - ISTREAM_BASE;
  assign out_rel = wbs_adr_i - c_ostream_base;
  assign in_hit  = (in_rel < c_span);
  assign out_hit = (out_rel < c_span);

  assign in_idx  = in_rel[SLOT_SHIFT +: c_chan_w];
  assign out_idx = out_rel[SLOT_SHIFT +: c_chan_w];

  assign rd_in_status  = xfer && !wbs_we_i && in_hit
                         && (in_rel[SLOT_SHIFT-1:0] == OFS_STATUS);
  assign wr_in_data    = xfer && wbs_we_i && in_hit
                         && (in_rel[SLOT_SHIFT-1:0] == OFS_DATA);
  assign rd_out_status = xfer && !wbs_we_i && out_hit
                         && (out_rel[SLOT_SHIFT-1:0] == OFS_STATUS);
  assign rd_out_data   = xfer && !wbs_we_i && out_hit
                         && (out_rel[SLOT_SHIFT-1:0] == OFS_DATA);

  ////////////////////////////////////////////////////////////
  // per-channel queues
  ////////////////////////////////////////////////////////////

  logic [p_num_chan-1:0] in_enq_val;
  logic [p_num_chan-1:0] in_enq_rdy;
  logic [p_num_chan-1:0] out_deq_val;
  logic [p_num_chan-1:0] out_deq_rdy;
  logic [DATA_W-1:0]     out_deq_data [p_num_chan];

  for (genvar k = 0; k < p_num_chan; k++) begin : g_chan
    assign in_enq_val[k]  = wr_in_data && (in_idx == k);
    // pop on the data read itself, the fifo ignores it when empty
    assign out_deq_rdy[k] = rd_out_data && (out_idx == k);

    stream_fifo #(
      .p_depth    (p_num_msgs)
    ) u_in_fifo (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .enq_val_i  (in_enq_val[k]),
      .enq_data_i (wbs_dat_i),
      .enq_rdy_o  (in_enq_rdy[k]),
      .deq_val_o  (in_val_o[k]),
      .deq_data_o (in_data_o[k]),
      .deq_rdy_i  (in_rdy_i[k])
    );

    stream_fifo #(
      .p_depth    (p_num_msgs)
    ) u_out_fifo (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .enq_val_i  (out_val_i[k]),
      .enq_data_i (out_data_i[k]),
      .enq_rdy_o  (out_rdy_o[k]),
      .deq_val_o  (out_deq_val[k]),
      .deq_data_o (out_deq_data[k]),
      .deq_rdy_i  (out_deq_rdy[k])
    );
  end

  ////////////////////////////////////////////////////////////
  // read data and ack
  ////////////////////////////////////////////////////////////

  always_comb begin
    wbs_dat_o = '0;
    if (rd_in_status) begin
      wbs_dat_o = DATA_W'(in_enq_rdy[in_idx]);
    end else if (rd_out_status) begin
      wbs_dat_o = DATA_W'(out_deq_val[out_idx]);
    end else if (rd_out_data && out_deq_val[out_idx]) begin
      wbs_dat_o = out_deq_data[out_idx];
    end
  end

  assign wbs_ack_o = 1'b1;

  // the two address windows and offsets never overlap
  a_one_decode: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0({rd_in_status, wr_in_data, rd_out_status, rd_out_data}));

endmodule

//--- wb_stream_top.sv
/* wishbone stream accelerator, one accumulate and clip pipeline per channel
   with nothing blocked a written sample shows in the output status 4 cycles later */
`timescale 1ns/1ns

module wb_stream_top import stream_pkg::*; #(
  parameter int p_num_chan   = 2,
  parameter int p_num_msgs   = 2,
  parameter int p_clip_limit = 1000
) (
  input  logic              clk,
  input  logic              rst_n_i,

  input  logic              wbs_cyc_i,
  input  logic              wbs_stb_i,
  input  logic              wbs_we_i,
  input  logic [DATA_W-1:0] wbs_adr_i,
  input  logic [DATA_W-1:0] wbs_dat_i,
  output logic              wbs_ack_o,
  output logic [DATA_W-1:0] wbs_dat_o
);

  // bridge to accumulate
  logic [p_num_chan-1:0] in_val;
  logic [DATA_W-1:0]     in_data [p_num_chan];
  logic [p_num_chan-1:0] in_rdy;

  // accumulate to clip
  logic [p_num_chan-1:0] mid_val;
  logic [DATA_W-1:0]     mid_data [p_num_chan];
  logic [p_num_chan-1:0] mid_rdy;

  // clip to bridge
  logic [p_num_chan-1:0] out_val;
  logic [DATA_W-1:0]     out_data [p_num_chan];
  logic [p_num_chan-1:0] out_rdy;

  wb_stream_bridge #(
    .p_num_chan (p_num_chan),
    .p_num_msgs (p_num_msgs)
  ) u_bridge (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .wbs_cyc_i  (wbs_cyc_i),
    .wbs_stb_i  (wbs_stb_i),
    .wbs_we_i   (wbs_we_i),
    .wbs_adr_i  (wbs_adr_i),
    .wbs_dat_i  (wbs_dat_i),
    .wbs_ack_o  (wbs_ack_o),
    .wbs_dat_o  (wbs_dat_o),
    .in_val_o   (in_val),
    .in_data_o  (in_data),
    .in_rdy_i   (in_rdy),
    .out_val_i  (out_val),
    .out_data_i (out_data),
    .out_rdy_o  (out_rdy)
  );

  ////////////////////////////////////////////////////////////
  // per-channel pipelines
  ////////////////////////////////////////////////////////////

  for (genvar k = 0; k < p_num_chan; k++) begin : g_pipe
    stream_accum_stage u_accum (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .in_val_i   (in_val[k]),
      .in_data_i  (in_data[k]),
      .in_rdy_o   (in_rdy[k]),
      .out_val_o  (mid_val[k]),
      .out_data_o (mid_data[k]),
      .out_rdy_i  (mid_rdy[k])
    );

    stream_clip_stage #(
      .p_clip_limit (p_clip_limit)
    ) u_clip (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .in_val_i   (mid_val[k]),
      .in_data_i  (mid_data[k]),
      .in_rdy_o   (mid_rdy[k]),
      .out_val_o  (out_val[k]),
      .out_data_o (out_data[k]),
      .out_rdy_i  (out_rdy[k])
    );
  end

endmodule
